//--- common/fetch_pkg.sv
package fetch_pkg;

    localparam int addr_w = 32;
    localparam int word_w = 32;

    typedef logic [addr_w-1:0] addr_t;  // byte address
    typedef logic [word_w-1:0] word_t;  // one instruction memory word

    localparam addr_t reset_pc = 32'h0000_0200;

    // read request towards instruction memory, addr is always word aligned
    typedef struct packed {
        logic  req;   // one-cycle strobe
        addr_t addr;
    } mem_req_t;

    // read response, one valid pulse per request
    typedef struct packed {
        logic  valid;
        word_t data;
    } mem_rsp_t;

    // restart of the instruction stream
    typedef struct packed {
        logic  valid;
        addr_t target;  // may sit on a half-word boundary
    } redirect_t;

endpackage

//--- common/rvc_pkg.sv
package rvc_pkg;

    // instr[1:0], anything but 2'b11 is a 16-bit instruction
    typedef enum logic [1:0] {
        q0   = 2'b00,
        q1   = 2'b01,
        q2   = 2'b10,
        full = 2'b11  // 32-bit instruction
    } rvc_quadrant_e;

    // instr[15:13] of the compressed forms that get expanded
    typedef enum logic [2:0] {
        addi   = 3'b000,  // c.addi and c.nop in q1
        li     = 3'b010,  // c.li in q1
        mv_add = 3'b100   // c.mv and c.add in q2, told apart by bit 12
    } rvc_funct3_e;

    // major opcodes of the 32-bit forms produced by the expander
    typedef enum logic [6:0] {
        op_imm = 7'b0010011,
        op     = 7'b0110011
    } base_opcode_e;

    // one issued instruction
    typedef struct packed {
        fetch_pkg::addr_t pc;
        fetch_pkg::word_t inst;        // always the 32-bit form when legal
        logic             compressed;  // came from a 16-bit encoding
        logic             illegal;     // compressed pattern not handled
    } issue_t;

endpackage

//--- fetch/fetch_request.sv
module fetch_request (
    input  logic                 clk,
    input  logic                 n_rst,
    input  fetch_pkg::redirect_t redirect,
    input  fetch_pkg::addr_t     read_addr,
    input  fetch_pkg::mem_rsp_t  mem_rsp,
    output fetch_pkg::mem_req_t  mem_req,
    output logic                 word_arrived,
    output fetch_pkg::word_t     word
);
    logic busy;      // one read outstanding
    logic stale;     // outstanding read was issued before a redirect
    logic req_next;

    // a redirect holds the request back until the aligner has the new address
    assign req_next = !busy && !redirect.valid;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            mem_req <= '0;
            busy    <= 1'b0;
            stale   <= 1'b0;
        end else begin
            mem_req <= '{req: req_next, addr: read_addr};
            if (req_next) begin
                busy <= 1'b1;
            end else if (mem_rsp.valid) begin
                busy <= 1'b0;
            end
            if (mem_rsp.valid) begin
                stale <= 1'b0;  // the old response is consumed here
            end else if (busy && redirect.valid) begin
                stale <= 1'b1;
            end
        end
    end

    // a response landing together with a redirect is old as well
    assign word_arrived = mem_rsp.valid && !stale && !redirect.valid;
    assign word         = mem_rsp.data;

    // memory only answers reads that were asked for
    a_rsp_only_when_busy: assert property (@(posedge clk) disable iff (!n_rst)
        mem_rsp.valid |-> busy);

    // no second request before the first one has been answered
    a_one_outstanding: assert property (@(posedge clk) disable iff (!n_rst)
        mem_req.req |=> !mem_req.req until mem_rsp.valid);

endmodule

//--- fetch/fetch_aligner.sv
module fetch_aligner (
    input  logic                 clk,
    input  logic                 n_rst,
    input  fetch_pkg::redirect_t redirect,
    input  logic                 word_arrived,
    input  fetch_pkg::word_t     word,
    output logic                 done,
    output fetch_pkg::word_t     inst,
    output fetch_pkg::addr_t     pc,
    output fetch_pkg::addr_t     read_addr
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        aligned,  // next instruction starts in the low half of the next word
        combine,  // buffer holds the low half of a split 32-bit instruction
        reload,   // buffer holds a compressed upper half while the same word is read again
        skip_low  // redirect target is in the upper half of the next word
    } align_state_e;

    align_state_e state, next_state;
    logic [15:0]  buffer;
    addr_t        next_pc, next_read_addr;
    logic         finished;
    logic         upper_full;  // upper half starts a 32-bit instruction

    assign upper_full = word[17:16] == 2'b11;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state     <= aligned;
            pc        <= reset_pc;
            read_addr <= reset_pc;
        end else if (redirect.valid || word_arrived) begin
            state     <= next_state;
            pc        <= next_pc;
            read_addr <= next_read_addr;
        end
    end

    // only the upper half is ever needed after the word is gone
    always_ff @(posedge clk) begin
        if (word_arrived) begin
            buffer <= word[31:16];
        end
    end

    always_comb begin
        next_state     = state;
        next_pc        = pc;
        next_read_addr = read_addr;
        inst           = '0;
        finished       = 1'b0;
        if (redirect.valid) begin
            next_pc        = redirect.target;
            next_read_addr = {redirect.target[31:2], 2'b00};
            next_state     = redirect.target[1] ? skip_low : aligned;
        end else if (word_arrived) begin
            case (state)
                skip_low: begin
                    next_read_addr = read_addr + 32'd4;
                    if (upper_full) begin
                        next_state = combine;  // nothing to issue yet
                    end else begin
                        inst       = {16'h0000, word[31:16]};
                        next_pc    = pc + 32'd2;
                        finished   = 1'b1;
                        next_state = aligned;
                    end
                end
                combine: begin
                    inst     = {word[15:0], buffer};
                    next_pc  = pc + 32'd4;
                    finished = 1'b1;
                    if (upper_full) begin
                        next_read_addr = read_addr + 32'd4;  // stays in combine
                    end else begin
                        next_state = reload;
                    end
                end
                reload: begin
                    inst           = {16'h0000, buffer};
                    next_pc        = pc + 32'd2;
                    finished       = 1'b1;
                    next_read_addr = read_addr + 32'd4;
                    next_state     = aligned;
                end
                default: begin
                    finished = 1'b1;
                    if (word[1:0] != 2'b11) begin
                        inst    = {16'h0000, word[15:0]};
                        next_pc = pc + 32'd2;
                        if (upper_full) begin
                            next_read_addr = read_addr + 32'd4;
                            next_state     = combine;
                        end else begin
                            next_state = reload;  // two compressed in one word
                        end
                    end else begin
                        inst           = word;
                        next_pc        = pc + 32'd4;
                        next_read_addr = read_addr + 32'd4;
                    end
                end
            endcase
        end
    end

    assign done = finished;

    a_read_addr_aligned: assert property (@(posedge clk) disable iff (!n_rst)
        read_addr[1:0] == 2'b00);

    a_done_on_arrival: assert property (@(posedge clk) disable iff (!n_rst)
        done |-> word_arrived);

endmodule

//--- source/rvc_expander.sv
module rvc_expander (
    input  fetch_pkg::word_t raw,
    output fetch_pkg::word_t expanded,
    output logic             compressed,
    output logic             illegal
);
    import rvc_pkg::*;

    rvc_quadrant_e quadrant;
    rvc_funct3_e   funct3;
    logic [4:0]    rd;
    logic [4:0]    rs2;
    logic [11:0]   imm;  // ci-format immediate, sign extended

    assign quadrant   = rvc_quadrant_e'(raw[1:0]);
    assign funct3     = rvc_funct3_e'(raw[15:13]);
    assign rd         = raw[11:7];
    assign rs2        = raw[6:2];
    assign imm        = {{6{raw[12]}}, raw[12], raw[6:2]};
    assign compressed = quadrant != full;

    always_comb begin
        expanded = {16'h0000, raw[15:0]};  // unsupported forms pass zero extended
        illegal  = compressed;
        case (quadrant)
            full: begin
                expanded = raw;
                illegal  = 1'b0;
            end
            q1: begin
                if (funct3 == addi) begin
                    // c.nop is c.addi with rd and imm zero, giving addi x0,x0,0
                    expanded = {imm, rd, 3'b000, rd, op_imm};
                    illegal  = 1'b0;
                end else if (funct3 == li) begin
                    expanded = {imm, 5'd0, 3'b000, rd, op_imm};
                    illegal  = 1'b0;
                end
            end
            q2: begin
                // rs2 of zero selects c.jr, c.jalr or c.ebreak instead
                if (funct3 == mv_add && rs2 != 5'd0) begin
                    expanded = {7'b0000000, rs2, raw[12] ? rd : 5'd0, 3'b000, rd, op};
                    illegal  = 1'b0;
                end
            end
            default: begin
                illegal = 1'b1;  // nothing from q0 is handled
            end
        endcase
    end

endmodule

//--- source/issue_register.sv
module issue_register (
    input  logic             clk,
    input  logic             n_rst,
    input  logic             done,
    input  fetch_pkg::addr_t pc,
    input  fetch_pkg::word_t expanded,
    input  logic             compressed,
    input  logic             illegal,
    output rvc_pkg::issue_t  issue,
    output logic             issue_valid
);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= done;  // one pulse per finished instruction
        end
    end

    // holds the last instruction until the next one finishes
    always_ff @(posedge clk) begin
        if (done) begin
            issue <= '{pc: pc, inst: expanded, compressed: compressed, illegal: illegal};
        end
    end

endmodule

//--- source/fetch_unit.sv
module fetch_unit (
    input  logic                 clk,
    input  logic                 n_rst,
    input  fetch_pkg::redirect_t redirect,
    input  fetch_pkg::mem_rsp_t  mem_rsp,
    output fetch_pkg::mem_req_t  mem_req,
    output rvc_pkg::issue_t      issue,
    output logic                 issue_valid
);
    import fetch_pkg::*;

    logic  word_arrived;
    word_t word;
    addr_t read_addr;
    logic  done;
    word_t inst;      // raw aligned instruction
    addr_t pc;
    word_t expanded;
    logic  compressed;
    logic  illegal;

    fetch_request u_fetch_request (
        .clk          (clk),
        .n_rst        (n_rst),
        .redirect     (redirect),
        .read_addr    (read_addr),
        .mem_rsp      (mem_rsp),
        .mem_req      (mem_req),
        .word_arrived (word_arrived),
        .word         (word)
    );

    fetch_aligner u_fetch_aligner (
        .clk          (clk),
        .n_rst        (n_rst),
        .redirect     (redirect),
        .word_arrived (word_arrived),
        .word         (word),
        .done         (done),
        .inst         (inst),
        .pc           (pc),
        .read_addr    (read_addr)
    );

    rvc_expander u_rvc_expander (
        .raw        (inst),
        .expanded   (expanded),
        .compressed (compressed),
        .illegal    (illegal)
    );

    issue_register u_issue_register (
        .clk         (clk),
        .n_rst       (n_rst),
        .done        (done),
        .pc          (pc),
        .expanded    (expanded),
        .compressed  (compressed),
        .illegal     (illegal),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

endmodule

//--- test/tb_fetch_unit.sv
module tb_fetch_unit;
    import fetch_pkg::*;
    import rvc_pkg::*;

    localparam int max_rows = 16;
    localparam int max_wait = 40;  // cycles per wait

    typedef struct packed {
        addr_t start;     // nonzero opens a new segment
        word_t inst;      // as stored, upper half zero when compressed
        word_t expanded;  // 32-bit form expected at the output
        logic  illegal;
    } row_t;

    logic      clk;
    logic      n_rst;
    redirect_t redirect;
    mem_rsp_t  mem_rsp;
    mem_req_t  mem_req;
    issue_t    issue;
    logic      issue_valid;

    logic [15:0] imem [0:1023];  // half-words, byte address 0 to 7ff
    row_t        rows [0:max_rows-1];
    addr_t       row_pc [0:max_rows-1];
    int          n_rows;
    logic        mem_pending;
    addr_t       mem_addr;
    int          mem_delay;
    addr_t       last_addr;  // latest request
    addr_t       prev_addr;  // the request before it

    fetch_unit UUT (
        .clk         (clk),
        .n_rst       (n_rst),
        .redirect    (redirect),
        .mem_rsp     (mem_rsp),
        .mem_req     (mem_req),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    function automatic logic is_compressed(input word_t inst);
        return inst[1:0] != 2'b11;
    endfunction

    function automatic word_t read_word(input addr_t addr);
        return {imem[{addr[10:2], 1'b1}], imem[{addr[10:2], 1'b0}]};
    endfunction

    task automatic add_row(input addr_t start, input word_t inst, input word_t expanded,
                           input logic illegal);
        rows[n_rows] = {start, inst, expanded, illegal};
        n_rows = n_rows + 1;
    endtask

    task automatic load_program();
        add_row(32'h200, 32'h00500093, 32'h00500093, 1'b0);  // addi x1,x0,5
        add_row(32'h000, 32'h00108133, 32'h00108133, 1'b0);  // add x2,x1,x1
        add_row(32'h000, 32'h123452b7, 32'h123452b7, 1'b0);  // lui x5
        add_row(32'h000, 32'h0000040d, 32'h00340413, 1'b0);  // c.addi x8,3
        add_row(32'h000, 32'h000054fd, 32'hfff00493, 1'b0);  // c.li x9,-1 in the same word
        add_row(32'h000, 32'h0000852e, 32'h00b00533, 1'b0);  // c.mv x10,x11
        add_row(32'h000, 32'h00b50633, 32'h00b50633, 1'b0);  // add split across words
        add_row(32'h000, 32'h000096ba, 32'h00e686b3, 1'b0);  // c.add x13,x14
        add_row(32'h000, 32'h00000001, 32'h00000013, 1'b0);  // c.nop
        add_row(32'h000, 32'h00004000, 32'h00004000, 1'b1);  // c.lw, not handled
        add_row(32'h000, 32'h02a00793, 32'h02a00793, 1'b0);  // addi x15,x0,42
        add_row(32'h000, 32'h00008082, 32'h00008082, 1'b1);  // c.jr, not handled
        add_row(32'h302, 32'h0000429d, 32'h00700293, 1'b0);  // c.li x5,7 at a half-word target
        add_row(32'h000, 32'h00128293, 32'h00128293, 1'b0);  // addi x5,x5,1
        add_row(32'h402, 32'h00528333, 32'h00528333, 1'b0);  // split add at a half-word target
        add_row(32'h000, 32'h00008316, 32'h00500333, 1'b0);  // c.mv x6,x5
    endtask

    task automatic build_memory();
        for (int i = 0; i < 1024; i++) begin
            imem[i] = {i[13:0], 2'b11};  // filler reads as a chain of 32-bit instructions
        end
        for (int i = 0; i < n_rows; i++) begin
            if (rows[i].start != 0) begin
                row_pc[i] = rows[i].start;
            end else begin
                row_pc[i] = row_pc[i-1] + (is_compressed(rows[i-1].inst) ? 2 : 4);
            end
            imem[row_pc[i][10:1]] = rows[i].inst[15:0];
            if (!is_compressed(rows[i].inst)) begin
                imem[row_pc[i][10:1] + 1] = rows[i].inst[31:16];
            end
        end
    endtask

    // memory model, one read at a time, 1 to 4 cycles from request to response
    initial begin
        void'($urandom(179));
        mem_rsp     = '0;
        mem_pending = 1'b0;
        mem_delay   = 0;
        last_addr   = '0;
        prev_addr   = '0;
        forever begin
            @(posedge clk);
            mem_rsp <= '0;
            if (mem_req.req) begin
                mem_pending = 1'b1;
                mem_addr    = mem_req.addr;
                mem_delay   = $urandom % 4;
                prev_addr  <= last_addr;
                last_addr  <= mem_req.addr;
            end
            if (mem_pending) begin
                if (mem_delay == 0) begin
                    mem_rsp    <= {1'b1, read_word(mem_addr)};
                    mem_pending = 1'b0;
                end else begin
                    mem_delay = mem_delay - 1;
                end
            end
        end
    end

    task automatic wait_request(input logic quiet);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            if (quiet) begin
                compare_value("issue_valid", issue_valid, 32'd0);
            end
            if (!mem_req.req && cycles == max_wait) begin
                fail_run("timeout, the DUT issued no memory request");
            end
            cycles = cycles + 1;
        end while (!mem_req.req);
    endtask

    task automatic wait_response();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            compare_value("issue_valid", issue_valid, 32'd0);  // nothing before the first word
            if (!mem_rsp.valid && cycles == max_wait) begin
                fail_run("timeout, the memory model never answered");
            end
            cycles = cycles + 1;
        end while (!mem_rsp.valid);
    endtask

    task automatic wait_issue(input int row);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            if (!issue_valid && cycles == max_wait) begin
                fail_run($sformatf("timeout, instruction %0d was never issued", row));
            end
            cycles = cycles + 1;
        end while (!issue_valid);
    endtask

    // redirect while the read just requested is still outstanding
    task automatic redirect_to(input addr_t target);
        wait_request(1'b0);
        redirect <= {1'b1, target};
        @(posedge clk);
        redirect <= '0;
    endtask

    task automatic check_row(input int i);
        addr_t base;
        base = {row_pc[i][31:2], 2'b00};
        compare_value("issue.pc", issue.pc, row_pc[i]);
        compare_value("issue.inst", issue.inst, rows[i].expanded);
        compare_value("issue.compressed", issue.compressed, is_compressed(rows[i].inst));
        compare_value("issue.illegal", issue.illegal, rows[i].illegal);
        // an upper compressed half inside a stream comes from a second read of its word
        if (is_compressed(rows[i].inst) && row_pc[i][1] && rows[i].start == 0) begin
            compare_value("mem_req.addr (first read)", prev_addr, base);
            compare_value("mem_req.addr (repeated read)", last_addr, base);
        end
    endtask

    initial begin
        n_rst    = 1'b0;
        redirect = '0;
        n_rows   = 0;
        load_program();
        build_memory();
        repeat (8) @(posedge clk);
        n_rst <= 1'b1;
        wait_request(1'b1);
        compare_value("mem_req.addr", mem_req.addr, 32'h0000_0200);
        wait_response();
        for (int i = 0; i < n_rows; i++) begin
            if (i > 0 && rows[i].start != 0) begin
                redirect_to(rows[i].start);
            end
            wait_issue(i);
            check_row(i);
        end
        $display("test passed");
        $finish;
    end

endmodule

//--- files.f
common/fetch_pkg.sv
common/rvc_pkg.sv
fetch/fetch_request.sv
fetch/fetch_aligner.sv
source/rvc_expander.sv
source/issue_register.sv
source/fetch_unit.sv
test/tb_fetch_unit.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  - common/fetch_pkg.sv
  - common/rvc_pkg.sv
  - fetch/fetch_request.sv
  - fetch/fetch_aligner.sv
  - source/rvc_expander.sv
  - source/issue_register.sv
  - source/fetch_unit.sv
  - target: test
    files:
      - test/tb_fetch_unit.sv
